//--- rtl/isa_pkg.sv
package isa_pkg;

    localparam int INSTR_W    = 32;
    localparam int OPCODE_W   = 6;
    localparam int FUNCT_W    = 6;
    localparam int SHAMT_W    = 5;
    localparam int REG_ADDR_W = 5;

    typedef logic [INSTR_W-1:0]    instr_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam reg_addr_t REG_ZERO = 5'd0;
    localparam reg_addr_t REG_RA   = 5'd31; // link register for jal

    // field view of an instruction word, R-type layout
    typedef struct packed {
        logic [OPCODE_W-1:0] opcode;
        reg_addr_t           rs;
        reg_addr_t           rt;
        reg_addr_t           rd;
        logic [SHAMT_W-1:0]  shamt;
        logic [FUNCT_W-1:0]  funct;
    } rtype_t;

    typedef enum logic [OPCODE_W-1:0] {
        OP_SPECIAL  = 6'h00,
        OP_J        = 6'h02,
        OP_JAL      = 6'h03,
        OP_BEQ      = 6'h04,
        OP_BNE      = 6'h05,
        OP_ADDI     = 6'h08,
        OP_ADDIU    = 6'h09,
        OP_SLTI     = 6'h0a,
        OP_ANDI     = 6'h0c,
        OP_ORI      = 6'h0d,
        OP_XORI     = 6'h0e,
        OP_LUI      = 6'h0f,
        OP_SPECIAL2 = 6'h1c,
        OP_LB       = 6'h20,
        OP_LH       = 6'h21,
        OP_LW       = 6'h23,
        OP_SB       = 6'h28,
        OP_SH       = 6'h29,
        OP_SW       = 6'h2b
    } opcode_e;

    typedef enum logic [FUNCT_W-1:0] {
        FN_SLL   = 6'h00,
        FN_SRL   = 6'h02,
        FN_SRA   = 6'h03,
        FN_JR    = 6'h08,
        FN_JALR  = 6'h09,
        FN_MFHI  = 6'h10,
        FN_MTHI  = 6'h11,
        FN_MFLO  = 6'h12,
        FN_MTLO  = 6'h13,
        FN_MULT  = 6'h18,
        FN_MULTU = 6'h19,
        FN_DIV   = 6'h1a,
        FN_DIVU  = 6'h1b,
        FN_ADD   = 6'h20,
        FN_ADDU  = 6'h21,
        FN_SUB   = 6'h22,
        FN_SUBU  = 6'h23,
        FN_AND   = 6'h24,
        FN_OR    = 6'h25,
        FN_XOR   = 6'h26,
        FN_NOR   = 6'h27,
        FN_SLT   = 6'h2a,
        FN_SLTU  = 6'h2b
    } funct_e;

    // SPECIAL2 functs overlap the SPECIAL ones, so they get their own type
    typedef enum logic [FUNCT_W-1:0] {
        S2_CLZ = 6'h20,
        S2_CLO = 6'h21
    } s2_funct_e;

    typedef enum logic [2:0] {
        CLS_NOP       = 3'd0,
        CLS_CALC_R    = 3'd1,
        CLS_CALC_I    = 3'd2,
        CLS_MEM_READ  = 3'd3,
        CLS_MEM_WRITE = 3'd4,
        CLS_BRANCH    = 3'd5,
        CLS_JUMP      = 3'd6,
        CLS_MULTDIV   = 3'd7
    } instr_class_e;

endpackage

//--- rtl/hazard_pkg.sv
package hazard_pkg;

    // cycles until use / until the result exists
    typedef logic [1:0] tcycle_t;

    localparam tcycle_t TUSE_INF = 2'd3; // source never read
    localparam tcycle_t T_ZERO   = 2'd0;

    // one in-flight instruction as seen by the hazard logic
    typedef struct packed {
        isa_pkg::reg_addr_t dest; // zero when nothing is written
        tcycle_t            tnew; // cycles left until forwardable
        isa_pkg::reg_addr_t rs;
        isa_pkg::reg_addr_t rt;
    } stage_rec_t;

    localparam stage_rec_t REC_BUBBLE = '0;

    typedef enum logic [1:0] {
        FWD_REG = 2'd0, // register file value
        FWD_MEM = 2'd1, // result sitting in MEM
        FWD_WB  = 2'd2  // result sitting in WB
    } fwd_sel_e;

endpackage

//--- rtl/instr_classify.sv
`timescale 1ns/100ps

module instr_classify (
    input  isa_pkg::instr_t       instr,
    output isa_pkg::instr_class_e iclass,
    output isa_pkg::reg_addr_t    rs,
    output isa_pkg::reg_addr_t    rt,
    output isa_pkg::reg_addr_t    dest
);
    import isa_pkg::*;

    rtype_t    f;
    opcode_e   op;
    funct_e    fn;
    s2_funct_e fn2;

    assign f   = rtype_t'(instr);
    assign op  = opcode_e'(f.opcode);
    assign fn  = funct_e'(f.funct);
    assign fn2 = s2_funct_e'(f.funct);

    assign rs = f.rs;
    assign rt = f.rt;

    always_comb begin
        iclass = CLS_NOP; // unknown words fall through to here
        case (op)
            OP_SPECIAL: begin
                case (fn)
                    FN_SLL, FN_SRL, FN_SRA,
                    FN_ADD, FN_ADDU, FN_SUB, FN_SUBU,
                    FN_AND, FN_OR, FN_XOR, FN_NOR,
                    FN_SLT, FN_SLTU:                     iclass = CLS_CALC_R;
                    FN_JR, FN_JALR:                      iclass = CLS_JUMP;
                    FN_MULT, FN_MULTU, FN_DIV, FN_DIVU,
                    FN_MFHI, FN_MFLO, FN_MTHI, FN_MTLO:  iclass = CLS_MULTDIV;
                    default:                             iclass = CLS_NOP;
                endcase
            end
            OP_SPECIAL2: begin
                if (fn2 == S2_CLZ || fn2 == S2_CLO) begin
                    iclass = CLS_CALC_R;
                end
            end
            OP_J, OP_JAL:                       iclass = CLS_JUMP;
            OP_BEQ, OP_BNE:                     iclass = CLS_BRANCH;
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_ANDI,
            OP_ORI, OP_XORI, OP_LUI:            iclass = CLS_CALC_I;
            OP_LW, OP_LB, OP_LH:                iclass = CLS_MEM_READ;
            OP_SW, OP_SB, OP_SH:                iclass = CLS_MEM_WRITE;
            default:                            iclass = CLS_NOP;
        endcase
    end

    // destination register per class
    always_comb begin
        dest = REG_ZERO;
        case (iclass)
            CLS_CALC_R:              dest = f.rd;
            CLS_CALC_I, CLS_MEM_READ: dest = f.rt;
            CLS_JUMP: begin
                if (op == OP_JAL) begin
                    dest = REG_RA;
                end else if (op == OP_SPECIAL && fn == FN_JALR) begin
                    dest = f.rd;
                end
            end
            CLS_MULTDIV: begin
                if (fn == FN_MFHI || fn == FN_MFLO) begin
                    dest = f.rd; // only the moves from hi/lo write the gpr file
                end
            end
            default:                 dest = REG_ZERO;
        endcase
    end

endmodule

//--- rtl/tuse_tnew_table.sv
`timescale 1ns/100ps

module tuse_tnew_table (
    input  isa_pkg::instr_t       instr,
    input  isa_pkg::instr_class_e iclass,
    output hazard_pkg::tcycle_t   tuse_rs,
    output hazard_pkg::tcycle_t   tuse_rt,
    output hazard_pkg::tcycle_t   tnew_id
);
    import isa_pkg::*;
    import hazard_pkg::*;

    rtype_t f;
    logic   is_special;
    logic   is_shift;
    logic   is_count; // clo / clz
    logic   is_lui;
    logic   is_link;
    logic   is_jreg;
    logic   is_mul_div;
    logic   is_mt;
    logic   is_mf;

    assign f          = rtype_t'(instr);
    assign is_special = opcode_e'(f.opcode) == OP_SPECIAL;

    assign is_shift   = is_special && (funct_e'(f.funct) inside {FN_SLL, FN_SRL, FN_SRA});
    assign is_count   = (opcode_e'(f.opcode) == OP_SPECIAL2)
                        && (s2_funct_e'(f.funct) inside {S2_CLZ, S2_CLO});
    assign is_lui     = opcode_e'(f.opcode) == OP_LUI;
    assign is_jreg    = is_special && (funct_e'(f.funct) inside {FN_JR, FN_JALR});
    assign is_link    = (opcode_e'(f.opcode) == OP_JAL)
                        || (is_special && funct_e'(f.funct) == FN_JALR);
    assign is_mul_div = is_special
                        && (funct_e'(f.funct) inside {FN_MULT, FN_MULTU, FN_DIV, FN_DIVU});
    assign is_mt      = is_special && (funct_e'(f.funct) inside {FN_MTHI, FN_MTLO});
    assign is_mf      = is_special && (funct_e'(f.funct) inside {FN_MFHI, FN_MFLO});

    always_comb begin
        tuse_rs = TUSE_INF;
        tuse_rt = TUSE_INF;
        tnew_id = T_ZERO;
        case (iclass)
            CLS_CALC_R: begin
                tuse_rs = is_shift ? TUSE_INF : 2'd1; // shamt form has no rs
                tuse_rt = is_count ? TUSE_INF : 2'd1;
                tnew_id = 2'd2;
            end
            CLS_CALC_I: begin
                tuse_rs = is_lui ? TUSE_INF : 2'd1;
                tnew_id = is_lui ? 2'd1 : 2'd2;
            end
            CLS_MEM_READ: begin
                tuse_rs = 2'd1; // address calc in EX
                tnew_id = 2'd3;
            end
            CLS_MEM_WRITE: begin
                tuse_rs = 2'd1;
                tuse_rt = 2'd2; // store data only needed in MEM
            end
            CLS_BRANCH: begin
                tuse_rs = 2'd0; // compared in ID
                tuse_rt = 2'd0;
            end
            CLS_JUMP: begin
                tuse_rs = is_jreg ? 2'd0 : TUSE_INF;
                tnew_id = is_link ? 2'd1 : T_ZERO; // pc+8 exists early
            end
            CLS_MULTDIV: begin
                if (is_mul_div) begin
                    tuse_rs = 2'd1;
                    tuse_rt = 2'd1;
                end else if (is_mt) begin
                    tuse_rs = 2'd1;
                end
                tnew_id = is_mf ? 2'd2 : T_ZERO;
            end
            default: begin
                tuse_rs = TUSE_INF;
                tuse_rt = TUSE_INF;
                tnew_id = T_ZERO;
            end
        endcase
    end

endmodule

//--- rtl/stage_tracker.sv
`timescale 1ns/100ps

module stage_tracker (
    input  logic                   clk,
    input  logic                   rst,
    input  hazard_pkg::stage_rec_t id_rec,
    input  logic                   bubble, // stall from hazard_detect
    output hazard_pkg::stage_rec_t ex_rec,
    output hazard_pkg::stage_rec_t mem_rec,
    output hazard_pkg::stage_rec_t wb_rec
);
    import hazard_pkg::*;

    // one stage of progress, tnew saturates at zero
    function automatic stage_rec_t advance(input stage_rec_t r);
        stage_rec_t n;
        n = r;
        if (r.tnew != T_ZERO) begin
            n.tnew = r.tnew - 2'd1;
        end
        return n;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_rec  <= REC_BUBBLE;
            mem_rec <= REC_BUBBLE;
            wb_rec  <= REC_BUBBLE;
        end else begin
            // ID holds during a stall, EX gets the bubble
            ex_rec  <= bubble ? REC_BUBBLE : advance(id_rec);
            mem_rec <= advance(ex_rec);
            wb_rec  <= advance(mem_rec);
        end
    end

endmodule

//--- rtl/hazard_detect.sv
`timescale 1ns/100ps

module hazard_detect (
    input  isa_pkg::instr_class_e  iclass,
    input  isa_pkg::reg_addr_t     rs,
    input  isa_pkg::reg_addr_t     rt,
    input  hazard_pkg::tcycle_t    tuse_rs,
    input  hazard_pkg::tcycle_t    tuse_rt,
    input  hazard_pkg::stage_rec_t ex_rec,
    input  hazard_pkg::stage_rec_t mem_rec,
    input  logic                   md_busy,
    output logic                   stall
);
    import isa_pkg::*;
    import hazard_pkg::*;

    logic stall_rs;
    logic stall_rt;
    logic stall_md;

    // producer in EX or MEM will not have its result in time
    function automatic logic src_stall(
        input reg_addr_t  src,
        input tcycle_t    tuse,
        input stage_rec_t ex_r,
        input stage_rec_t mem_r
    );
        logic late_ex;
        logic late_mem;
        late_ex  = (ex_r.dest == src) && (ex_r.tnew > tuse);
        late_mem = (mem_r.dest == src) && (mem_r.tnew > tuse);
        return (src != REG_ZERO) && (late_ex || late_mem);
    endfunction

    assign stall_rs = src_stall(rs, tuse_rs, ex_rec, mem_rec);
    assign stall_rt = src_stall(rt, tuse_rt, ex_rec, mem_rec);

    // hi/lo unit busy blocks every multdiv op in ID
    assign stall_md = (iclass == CLS_MULTDIV) && md_busy;

    assign stall = stall_rs || stall_rt || stall_md;

endmodule

//--- rtl/forward_select.sv
`timescale 1ns/100ps

module forward_select (
    input  isa_pkg::reg_addr_t     rs_id,
    input  isa_pkg::reg_addr_t     rt_id,
    input  hazard_pkg::stage_rec_t ex_rec,
    input  hazard_pkg::stage_rec_t mem_rec,
    input  hazard_pkg::stage_rec_t wb_rec,
    output hazard_pkg::fwd_sel_e   fwd_rs_id, // branch comparator in ID
    output hazard_pkg::fwd_sel_e   fwd_rt_id,
    output hazard_pkg::fwd_sel_e   fwd_rs_ex, // ALU operands in EX
    output hazard_pkg::fwd_sel_e   fwd_rt_ex
);
    import isa_pkg::*;
    import hazard_pkg::*;

    // MEM checked before WB so the youngest ready result wins
    function automatic fwd_sel_e pick(
        input reg_addr_t  src,
        input stage_rec_t mem_r,
        input stage_rec_t wb_r
    );
        fwd_sel_e sel;
        sel = FWD_REG;
        if (src != REG_ZERO) begin
            if (mem_r.dest == src && mem_r.tnew == T_ZERO) begin
                sel = FWD_MEM;
            end else if (wb_r.dest == src && wb_r.tnew == T_ZERO) begin
                sel = FWD_WB;
            end
        end
        return sel;
    endfunction

    assign fwd_rs_id = pick(rs_id, mem_rec, wb_rec);
    assign fwd_rt_id = pick(rt_id, mem_rec, wb_rec);

    // sources of the instruction now in EX travel in its record
    assign fwd_rs_ex = pick(ex_rec.rs, mem_rec, wb_rec);
    assign fwd_rt_ex = pick(ex_rec.rt, mem_rec, wb_rec);

endmodule

//--- rtl/pipeline_control.sv
`timescale 1ns/100ps

module pipeline_control (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 md_busy,
    input  isa_pkg::instr_t      instr_id,
    output logic                 stall_pc,
    output logic                 stall_id,
    output logic                 flush_ex,
    output hazard_pkg::fwd_sel_e fwd_rs_id,
    output hazard_pkg::fwd_sel_e fwd_rt_id,
    output hazard_pkg::fwd_sel_e fwd_rs_ex,
    output hazard_pkg::fwd_sel_e fwd_rt_ex
);
    import isa_pkg::*;
    import hazard_pkg::*;

    instr_class_e iclass;
    reg_addr_t    rs;
    reg_addr_t    rt;
    reg_addr_t    dest;
    tcycle_t      tuse_rs;
    tcycle_t      tuse_rt;
    tcycle_t      tnew_id;
    stage_rec_t   id_rec;
    stage_rec_t   ex_rec;
    stage_rec_t   mem_rec;
    stage_rec_t   wb_rec;
    logic         stall;

    instr_classify u_classify (
        .instr  (instr_id),
        .iclass (iclass),
        .rs     (rs),
        .rt     (rt),
        .dest   (dest)
    );

    tuse_tnew_table u_table (
        .instr   (instr_id),
        .iclass  (iclass),
        .tuse_rs (tuse_rs),
        .tuse_rt (tuse_rt),
        .tnew_id (tnew_id)
    );

    // record of the instruction in ID, enters EX next edge
    assign id_rec = '{dest: dest, tnew: tnew_id, rs: rs, rt: rt};

    stage_tracker u_tracker (
        .clk     (clk),
        .rst     (rst),
        .id_rec  (id_rec),
        .bubble  (stall),
        .ex_rec  (ex_rec),
        .mem_rec (mem_rec),
        .wb_rec  (wb_rec)
    );

    hazard_detect u_detect (
        .iclass  (iclass),
        .rs      (rs),
        .rt      (rt),
        .tuse_rs (tuse_rs),
        .tuse_rt (tuse_rt),
        .ex_rec  (ex_rec),
        .mem_rec (mem_rec),
        .md_busy (md_busy),
        .stall   (stall)
    );

    forward_select u_forward (
        .rs_id     (rs),
        .rt_id     (rt),
        .ex_rec    (ex_rec),
        .mem_rec   (mem_rec),
        .wb_rec    (wb_rec),
        .fwd_rs_id (fwd_rs_id),
        .fwd_rt_id (fwd_rt_id),
        .fwd_rs_ex (fwd_rs_ex),
        .fwd_rt_ex (fwd_rt_ex)
    );

    // freeze PC and ID, flush EX, all on the one level
    assign stall_pc = stall;
    assign stall_id = stall;
    assign flush_ex = stall;

endmodule

//--- dv/pipeline_control_props.sv
`timescale 1ns/100ps

module pipeline_control_props (
    input logic                   clk,
    input logic                   rst,
    input logic                   stall_pc,
    input logic                   stall_id,
    input logic                   flush_ex,
    input hazard_pkg::fwd_sel_e   fwd_rs_id,
    input hazard_pkg::fwd_sel_e   fwd_rt_id,
    input hazard_pkg::fwd_sel_e   fwd_rs_ex,
    input hazard_pkg::fwd_sel_e   fwd_rt_ex,
    input isa_pkg::reg_addr_t     rs,
    input isa_pkg::reg_addr_t     rt,
    input hazard_pkg::stage_rec_t ex_rec
);
    import hazard_pkg::*;

    stall_levels_equal: assert property (@(posedge clk) disable iff (rst)
        (stall_pc == stall_id) && (stall_id == flush_ex))
        else $error("stall_pc, stall_id and flush_ex disagree");

    // records were just cleared, nothing can be in flight
    idle_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !stall_id && fwd_rs_id == FWD_REG && fwd_rt_id == FWD_REG
                       && fwd_rs_ex == FWD_REG && fwd_rt_ex == FWD_REG)
        else $error("control outputs not idle after reset");

    no_fwd_reg_zero: assert property (@(posedge clk) disable iff (rst)
        (fwd_rs_id == FWD_REG || rs != '0) && (fwd_rt_id == FWD_REG || rt != '0)
        && (fwd_rs_ex == FWD_REG || ex_rec.rs != '0)
        && (fwd_rt_ex == FWD_REG || ex_rec.rt != '0))
        else $error("forward select points at register zero");

endmodule

bind pipeline_control pipeline_control_props u_props (
    .clk       (clk),
    .rst       (rst),
    .stall_pc  (stall_pc),
    .stall_id  (stall_id),
    .flush_ex  (flush_ex),
    .fwd_rs_id (fwd_rs_id),
    .fwd_rt_id (fwd_rt_id),
    .fwd_rs_ex (fwd_rs_ex),
    .fwd_rt_ex (fwd_rt_ex),
    .rs        (rs),
    .rt        (rt),
    .ex_rec    (ex_rec)
);

//--- dv/tb_pipeline_control.sv
`timescale 1ns/100ps

module tb_pipeline_control;
    import isa_pkg::*;
    import hazard_pkg::*;

    localparam int MAX_LINES = 128;

    logic     clk;
    logic     rst;
    logic     md_busy;
    instr_t   instr_id;
    logic     stall_pc;
    logic     stall_id;
    logic     flush_ex;
    fwd_sel_e fwd_rs_id;
    fwd_sel_e fwd_rt_id;
    fwd_sel_e fwd_rs_ex;
    fwd_sel_e fwd_rt_ex;

    // one entry per cycle from the pattern file
    int       pat_grp [MAX_LINES];
    instr_t   pat_instr [MAX_LINES];
    int       pat_exp [MAX_LINES][6]; // busy, stall, rs_id, rt_id, rs_ex, rt_ex
    int       n_lines;
    int       checks;
    int       errors;
    int       grp_checks;
    int       grp_errors;
    bit [31:0] lcg_state;

    pipeline_control DUT (
        .clk       (clk),
        .rst       (rst),
        .md_busy   (md_busy),
        .instr_id  (instr_id),
        .stall_pc  (stall_pc),
        .stall_id  (stall_id),
        .flush_ex  (flush_ex),
        .fwd_rs_id (fwd_rs_id),
        .fwd_rt_id (fwd_rt_id),
        .fwd_rs_ex (fwd_rs_ex),
        .fwd_rt_ex (fwd_rt_ex)
    );

    always #10 clk = ~clk;

    function automatic string group_name(input int g);
        case (g)
            1:       return "reset_idle";
            2:       return "load_use";
            3:       return "alu_to_branch";
            4:       return "store_and_zero";
            5:       return "multdiv_busy";
            6:       return "independent_pairs";
            7:       return "lcg_pairs";
            default: return "unknown";
        endcase
    endfunction

    function automatic bit [31:0] next_rand();
        lcg_state = (lcg_state * 32'd1103515245 + 32'd12345) & 32'h7fffffff;
        return lcg_state;
    endfunction

    task automatic load_patterns();
        int    fd;
        int    n;
        string line;
        int    g;
        int    v [6];
        instr_t w;
        fd = $fopen("dv/pipeline_patterns.txt", "r");
        n_lines = 0;
        if (fd == 0) begin
            $display("could not open the pattern file");
            errors++;
        end else begin
            while (!$feof(fd) && n_lines < MAX_LINES) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%d %h %d %d %d %d %d %d", g, w,
                                v[0], v[1], v[2], v[3], v[4], v[5]);
                    if (n == 8) begin
                        pat_grp[n_lines]   = g;
                        pat_instr[n_lines] = w;
                        for (int k = 0; k < 6; k++) begin
                            pat_exp[n_lines][k] = v[k];
                        end
                        n_lines++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic compare_field(input string tname, input string field,
                                 input int exp, input int act);
        checks++;
        grp_checks++;
        if (exp != act) begin
            errors++;
            grp_errors++;
            $display("CHECK FAILED %s %s: expected %0d actual %0d", tname, field, exp, act);
        end
    endtask

    // drive after the edge, look at the settled outputs on the falling edge
    task automatic drive_cycle(input instr_t w, input logic busy);
        @(posedge clk);
        #2;
        instr_id = w;
        md_busy  = busy;
        @(negedge clk);
    endtask

    task automatic check_outputs(input string tname, input int exp [6]);
        compare_field(tname, "stall_pc", exp[1], int'(stall_pc));
        compare_field(tname, "stall_id", exp[1], int'(stall_id));
        compare_field(tname, "flush_ex", exp[1], int'(flush_ex));
        compare_field(tname, "fwd_rs_id", exp[2], int'(fwd_rs_id));
        compare_field(tname, "fwd_rt_id", exp[3], int'(fwd_rt_id));
        compare_field(tname, "fwd_rs_ex", exp[4], int'(fwd_rs_ex));
        compare_field(tname, "fwd_rt_ex", exp[5], int'(fwd_rt_ex));
    endtask

    task automatic report_group(input int g);
        $display("test %s done: %0d checks, %0d errors", group_name(g), grp_checks, grp_errors);
        grp_checks = 0;
        grp_errors = 0;
    endtask

    task automatic wait_idle();
        int cnt;
        cnt = 0;
        while ((stall_id || fwd_rs_ex != FWD_REG || fwd_rt_ex != FWD_REG) && cnt < 8) begin
            drive_cycle('0, 1'b0);
            cnt++;
        end
        if (stall_id || fwd_rs_ex != FWD_REG || fwd_rt_ex != FWD_REG) begin
            errors++;
            $display("pipeline did not drain within 8 cycles");
        end
    endtask

    initial begin
        #200000;
        $display("simulation ran too long, stopping");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int     idle_exp [6];
        int     cur_grp;
        instr_t w;
        logic   was_stalled;
        clk        = 1'b0;
        rst        = 1'b1;
        md_busy    = 1'b0;
        instr_id   = '0;
        checks     = 0;
        errors     = 0;
        grp_checks = 0;
        grp_errors = 0;
        lcg_state  = 32'd4446;
        idle_exp   = '{0, 0, 0, 0, 0, 0};
        load_patterns();

        repeat (16) @(posedge clk);
        #2 rst = 1'b0;

        was_stalled = 1'b0;
        cur_grp = (n_lines > 0) ? pat_grp[0] : 0;
        for (int i = 0; i < n_lines; i++) begin
            if (pat_grp[i] != cur_grp) begin
                report_group(cur_grp);
                cur_grp = pat_grp[i];
            end
            if (was_stalled && pat_instr[i] != instr_id) begin
                errors++;
                $display("pattern line %0d changes the instruction during a stall", i);
            end
            drive_cycle(pat_instr[i], pat_exp[i][0] != 0);
            check_outputs(group_name(cur_grp), pat_exp[i]);
            was_stalled = stall_id;
        end
        if (n_lines > 0) begin
            report_group(cur_grp);
        end

        // extra pairs: dests 1..15, sources 16..31, so never dependent
        wait_idle();
        for (int i = 0; i < 16; i++) begin
            bit [31:0] r;
            r = next_rand();
            w = {6'h00, 5'd16 + 5'(r[7:4]), 5'd16 + 5'(r[11:8]),
                 5'd1 + 5'(r[19:16] % 15), 5'd0, 6'h21};
            drive_cycle(w, 1'b0);
            check_outputs(group_name(7), idle_exp);
        end
        report_group(7);

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
rtl/isa_pkg.sv
rtl/hazard_pkg.sv
rtl/instr_classify.sv
rtl/tuse_tnew_table.sv
rtl/stage_tracker.sv
rtl/hazard_detect.sv
rtl/forward_select.sv
rtl/pipeline_control.sv
dv/pipeline_control_props.sv
dv/tb_pipeline_control.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_pipeline_control
FLIST     ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FLIST)) $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/pipeline_patterns.txt
# group instr busy stall fwd_rs_id fwd_rt_id fwd_rs_ex fwd_rt_ex
# selects 0 reg file, 1 mem, 2 wb; one line per cycle, stalled lines repeat
1 00000000 0 0 0 0 0 0
1 00000000 0 0 0 0 0 0
2 8c410000 0 0 0 0 0 0
2 00241820 0 1 0 0 0 0
2 00241820 0 0 0 0 0 0
2 00000000 0 0 0 0 2 0
2 00000000 0 0 0 0 0 0
2 00000000 0 0 0 0 0 0
2 8c450000 0 0 0 0 0 0
2 10a60000 0 1 0 0 0 0
2 10a60000 0 1 0 0 0 0
2 10a60000 0 0 2 0 0 0
2 00000000 0 0 0 0 0 0
2 00000000 0 0 0 0 0 0
2 00000000 0 0 0 0 0 0
3 00223820 0 0 0 0 0 0
3 10e00000 0 1 0 0 0 0
3 10e00000 0 0 1 0 0 0
3 00000000 0 0 0 0 2 0
3 00000000 0 0 0 0 0 0
3 00000000 0 0 0 0 0 0
4 00224020 0 0 0 0 0 0
4 ad280000 0 0 0 0 0 0
4 00000000 0 0 0 0 0 1
4 00000000 0 0 0 0 0 0
4 00000000 0 0 0 0 0 0
4 00220020 0 0 0 0 0 0
4 00001820 0 0 0 0 0 0
4 00000000 0 0 0 0 0 0
4 00000000 0 0 0 0 0 0
4 8c400000 0 0 0 0 0 0
4 00001820 0 0 0 0 0 0
4 00000000 0 0 0 0 0 0
4 00000000 0 0 0 0 0 0
4 00000000 0 0 0 0 0 0
5 00220018 1 1 0 0 0 0
5 00220018 1 1 0 0 0 0
5 00220018 1 1 0 0 0 0
5 00220018 0 0 0 0 0 0
5 00221820 1 0 0 0 0 0
5 00000000 0 0 0 0 0 0
5 00000000 0 0 0 0 0 0
5 00000000 0 0 0 0 0 0
6 356a1234 0 0 0 0 0 0
6 01ae6021 0 0 0 0 0 0
6 00000000 0 0 0 0 0 0
6 260f0005 0 0 0 0 0 0
6 0253882a 0 0 0 0 0 0
6 00000000 0 0 0 0 0 0
6 00000000 0 0 0 0 0 0
